// File: Makefile
TOP = rv_decode_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f rv_decode.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: include/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

`define RV_XLEN 32
`define RV_RADDR_W 5
`define RV_CADDR_W 12

// Implemented machine CSRs
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

`define RV_RESET_TVEC 32'h0000_0100  // Trap vector out of reset

`endif

// File: rv_decode.f
+incdir+include
verilog/rv_decode_pkg.sv
verilog/instr_decoder.sv
verilog/decode_stage.sv
verilog/csr_file.sv
verilog/csr_port_arbiter.sv
verilog/rv_decode_top.sv
testbench/rv_decode_tb.sv

// File: testbench/rv_decode_tb.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module rv_decode_tb;
  import rv_decode_pkg::*;

  localparam int clk_period = 4;
  localparam int n_rounds = 8;
  // Decode rounds plus the directed exception, hazard, flush and APB sequences
  localparam int test_cycles = 4 + n_rounds * 7 * 2 + 80;

  localparam alu_op_t alu_tab [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                                      alu_xor, alu_srl, alu_or, alu_and};
  localparam logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
  localparam lsu_op_t load_tab [5] = '{lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu};
  localparam lsu_op_t store_tab [3] = '{lsu_sb, lsu_sh, lsu_sw};
  localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam bcu_op_t br_tab [6] = '{bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu};

  logic clock;
  logic reset;
  fetch_in_t fetch;
  stage_hazard_t ex_state;
  stage_hazard_t mem_state;
  logic flush;
  reg_read_req_t reg_read;
  decode_instr_t decoded;
  logic stall;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`RV_CADDR_W-1:0] paddr;
  logic [`RV_XLEN-1:0] pwdata;
  logic [`RV_XLEN-1:0] prdata;
  logic pready;
  logic pslverr;
  logic [31:0] rng;

  rv_decode_top rv_decode_top_inst (
    .clock, .reset, .fetch, .ex_state, .mem_state, .flush, .reg_read, .decoded, .stall,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng = xorshift(rng);
    r = rng;
  endtask

  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_record(input string name, input decode_instr_t exp,
                              input decode_instr_t act, input decode_instr_t mask);
    if ((exp & mask) !== (act & mask)) begin
      $display("ERR %s expected %h actual %h", name, exp & mask, act & mask);
      stop_with_failure();
    end
  endtask

  task automatic check_read(input string name, input reg_read_req_t exp,
                            input reg_read_req_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  // Fields checked on a decode; cdata and most op flags are skipped
  function automatic decode_instr_t rec_mask(input logic imm_used, input logic alu_used);
    decode_instr_t m;
    m = '1;
    m.cdata = '0;
    m.op = '0;
    m.op.valid = 1'b1;
    m.op.exception = 1'b1;
    if (!imm_used) m.imm = '0;
    if (!alu_used) m.alu_op = alu_add;
    return m;
  endfunction

  task automatic present(input logic [31:0] addr, input logic [31:0] word,
                         input stage_hazard_t ex, input stage_hazard_t mem, input logic fl);
    @(posedge clock);
    fetch <= '{pc: addr, instr: word, valid: 1'b1};
    ex_state <= ex;
    mem_state <= mem;
    flush <= fl;
    @(negedge clock);  // Combinational outputs settled
  endtask

  task automatic capture();
    @(posedge clock);
    @(negedge clock);
  endtask

  task automatic drop_fetch();
    @(posedge clock);
    fetch.valid <= 1'b0;
  endtask

  task automatic complete_access(output logic [31:0] data, output logic err);
    @(negedge clock);
    while (!pready) @(negedge clock);
    data = prdata;
    err = pslverr;
    @(posedge clock);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_transfer(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic err);
    @(posedge clock);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clock);
    penable <= 1'b1;
    complete_access(data, err);
  endtask

  task automatic decode_fields();
    decode_instr_t e;
    reg_read_req_t rq;
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] pc;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [11:0] i12;
    logic [20:0] off;
    logic imm_used;
    logic alu_used;
    int idx;
    for (int n = 0; n < n_rounds; n++) begin
      for (int k = 0; k < 7; k++) begin
        next_random(r);
        rd = r[4:0];
        rs1 = r[9:5];
        rs2 = r[14:10];
        f3 = r[17:15];
        i12 = r[29:18];
        next_random(r);
        pc = {r[31:2], 2'b00};
        next_random(r);
        off = {r[31:12], 1'b0};
        e = '0;
        rq = '0;
        rq.rden1 = 1'b1;
        rq.rden2 = 1'b1;
        imm_used = 1'b1;
        alu_used = 1'b0;
        case (k)
          0: begin  // Alternate funct7 only for sub and sra
            w = {1'b0, r[0] & (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd, 7'b0110011};
            e.alu_op = w[30] ? ((f3 == 3'd0) ? alu_sub : alu_sra) : alu_tab[f3];
            imm_used = 1'b0;
            alu_used = 1'b1;
          end
          1: begin
            f3 = (f3[1:0] == 2'b01) ? f3 ^ 3'b001 : f3;  // No shifts
            w = {i12, rs1, f3, rd, 7'b0010011};
            e.imm = {{20{i12[11]}}, i12};
            e.alu_op = alu_tab[f3];
            alu_used = 1'b1;
            rq.rden2 = 1'b0;
          end
          2: begin
            idx = int'(r[15:0] % 16'd5);
            w = {i12, rs1, load_f3[idx], rd, 7'b0000011};
            e.imm = {{20{i12[11]}}, i12};
            e.lsu_op = load_tab[idx];
            rq.rden2 = 1'b0;
          end
          3: begin
            idx = int'(r[15:0] % 16'd3);
            w = {i12[11:5], rs2, rs1, 3'(idx), i12[4:0], 7'b0100011};
            e.imm = {{20{i12[11]}}, i12};
            e.lsu_op = store_tab[idx];
          end
          4: begin
            idx = int'(r[15:0] % 16'd6);
            w = {off[12], off[10:5], rs2, rs1, br_f3[idx], off[4:1], off[11], 7'b1100011};
            e.imm = {{19{off[12]}}, off[12:0]};
            e.bcu_op = br_tab[idx];
          end
          5: begin
            w = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            e.imm = {{11{off[20]}}, off};
            rq.rden1 = 1'b0;
            rq.rden2 = 1'b0;
          end
          default: begin
            w = {r[31:12], rd, 7'b0110111};
            e.imm = {r[31:12], 12'h000};
            e.alu_op = alu_pass_b;
            alu_used = 1'b1;
            rq.rden1 = 1'b0;
            rq.rden2 = 1'b0;
          end
        endcase
        e.pc = pc;
        e.npc = pc + 32'd4;
        e.instr = w;
        e.waddr = w[11:7];
        e.raddr1 = w[19:15];
        e.raddr2 = w[24:20];
        e.caddr = w[31:20];
        e.op.valid = 1'b1;
        rq.raddr1 = e.raddr1;
        rq.raddr2 = e.raddr2;
        present(pc, w, '0, '0, 1'b0);
        check_read($sformatf("read_kind%0d_round%0d", k, n), rq, reg_read);
        capture();
        check_record($sformatf("decode_kind%0d_round%0d", k, n), e, decoded,
                     rec_mask(imm_used, alu_used));
      end
    end
  endtask

  task automatic exception_case(input string name, input logic [31:0] word,
                                input except_cause_t cause, input logic tval_used);
    decode_instr_t e;
    decode_instr_t m;
    e = '0;
    m = '0;
    e.op.exception = 1'b1;
    m.op.exception = 1'b1;
    e.ecause = cause;
    m.ecause = except_cause_t'(4'hf);
    if (tval_used) begin
      e.etval = word;
      m.etval = '1;
    end
    present(32'h0000_0080, word, '0, '0, 1'b0);
    capture();
    check_record(name, e, decoded, m);
  endtask

  task automatic hazard_case(input string name, input logic [31:0] word,
                             input stage_hazard_t ex, input stage_hazard_t mem,
                             input logic exp_stall);
    present(32'h0000_0100, word, ex, mem, 1'b0);
    check_bit({name, "_stall"}, exp_stall, stall);
    capture();
    check_bit({name, "_valid"}, !exp_stall, decoded.op.valid);  // Bubble clears valid
  endtask

  task automatic hazard_stalls();
    stage_hazard_t ex;
    stage_hazard_t mem;
    logic [31:0] addi_w;
    logic [31:0] lui_w;
    addi_w = {12'h010, 5'd3, 3'b000, 5'd4, 7'b0010011};  // addi x4, x3, 16
    lui_w = {12'h000, 5'd3, 3'b000, 5'd9, 7'b0110111};
    ex = '0;
    mem = '0;
    ex.op.load = 1'b1;
    ex.waddr = 5'd3;
    hazard_case("load_use", addi_w, ex, mem, 1'b1);
    ex.waddr = 5'd7;
    hazard_case("load_other_reg", addi_w, ex, mem, 1'b0);
    ex.waddr = 5'd3;
    hazard_case("load_no_rden", lui_w, ex, mem, 1'b0);
    ex = '0;
    ex.op.division = 1'b1;
    hazard_case("ex_division", addi_w, ex, mem, 1'b1);
    ex = '0;
    ex.op.cwren = 1'b1;
    hazard_case("ex_csr_write", addi_w, ex, mem, 1'b1);
    ex = '0;
    mem.op.cwren = 1'b1;
    hazard_case("mem_csr_write", addi_w, ex, mem, 1'b1);
  endtask

  task automatic flush_and_hold();
    stage_hazard_t ex;
    logic [31:0] a_w;
    logic [31:0] b_w;
    a_w = {12'h010, 5'd3, 3'b000, 5'd4, 7'b0010011};
    b_w = {12'hfff, 5'd4, 3'b111, 5'd5, 7'b0010011};  // andi x5, x4, -1
    ex = '0;
    ex.op.load = 1'b1;
    ex.waddr = 5'd3;
    present(32'h0000_0400, a_w, ex, '0, 1'b1);
    check_bit("flush_stall", 1'b0, stall);
    capture();
    check_bit("flush_bubble", 1'b0, decoded.op.valid);
    present(32'h0000_0404, a_w, '0, '0, 1'b0);
    capture();
    check_word("hold_setup", 32'h0000_0404, decoded.pc);
    ex = '0;
    ex.stall = 1'b1;
    present(32'h0000_0408, b_w, ex, '0, 1'b0);
    capture();
    capture();
    check_word("hold_instr", a_w, decoded.instr);
    check_word("hold_pc", 32'h0000_0404, decoded.pc);
    present(32'h0000_040c, b_w, '0, '0, 1'b0);
    capture();
    check_word("release_instr", b_w, decoded.instr);
    check_word("release_pc", 32'h0000_040c, decoded.pc);
  endtask

  task automatic csr_access();
    logic [31:0] v;
    logic [31:0] data;
    logic err;
    next_random(v);
    drop_fetch();
    apb_transfer(1'b1, `CSR_MSCRATCH, v, data, err);
    check_bit("apb_write_err", 1'b0, err);
    // csrrs x6, mscratch, x0
    present(32'h0000_0200, {`CSR_MSCRATCH, 5'd0, 3'b010, 5'd6, 7'b1110011}, '0, '0, 1'b0);
    capture();
    check_word("csrrs_cdata", v, decoded.cdata);
    check_bit("csrrs_exception", 1'b0, decoded.op.exception);
    drop_fetch();
    apb_transfer(1'b0, `CSR_MSCRATCH, 32'h0, data, err);
    check_word("apb_read_data", v, data);
    check_bit("apb_read_err", 1'b0, err);
    apb_transfer(1'b0, 12'h7c0, 32'h0, data, err);
    check_bit("apb_unmapped_err", 1'b1, err);
  endtask

  task automatic apb_contention();
    logic [31:0] v;
    logic [31:0] data;
    logic err;
    next_random(v);
    @(posedge clock);
    fetch <= '{pc: 32'h0000_0300, instr: {`CSR_MSTATUS, 5'd0, 3'b010, 5'd7, 7'b1110011},
               valid: 1'b1};
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= `CSR_MSCRATCH;
    pwdata <= v;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    check_bit("apb_blocked", 1'b0, pready);
    @(posedge clock);
    fetch.valid <= 1'b0;  // Decode read ends here
    complete_access(data, err);
    check_bit("apb_late_err", 1'b0, err);
    apb_transfer(1'b0, `CSR_MSCRATCH, 32'h0, data, err);
    check_word("apb_late_data", v, data);
  endtask

  initial begin
    #((test_cycles + 100) * clk_period);
    $display("The tests did not finish in time");
    stop_with_failure();
  end

  initial begin
    rng = 32'd64;
    reset = 1'b0;
    fetch = '0;
    ex_state = '0;
    mem_state = '0;
    flush = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_record("reset_record", '0, decoded, '1);
    check_bit("reset_stall", 1'b0, stall);
    check_bit("reset_pready", 1'b0, pready);
    check_bit("reset_pslverr", 1'b0, pslverr);
    decode_fields();
    exception_case("illegal_zero", 32'h0000_0000, except_illegal_instruction, 1'b1);
    exception_case("ebreak", 32'h0010_0073, except_breakpoint, 1'b0);
    exception_case("ecall", 32'h0000_0073, except_env_call_mach, 1'b0);
    exception_case("csr_unmapped", {12'h7c0, 5'd0, 3'b010, 5'd1, 7'b1110011},
                   except_illegal_instruction, 1'b1);
    hazard_stalls();
    flush_and_hold();
    csr_access();
    apb_contention();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module csr_file (
  input  logic clock,
  input  logic reset,
  input  rv_decode_pkg::csr_req_t req,
  output rv_decode_pkg::csr_rsp_t rsp
);
  localparam logic [`RV_XLEN-1:0] mstatus_mask = `RV_XLEN'('h88);  // MIE and MPIE

  logic [`RV_XLEN-1:0] mstatus;
  logic [`RV_XLEN-1:0] mscratch;
  logic [`RV_XLEN-1:0] mtvec;
  logic [`RV_XLEN-1:0] mepc;
  logic [`RV_XLEN-1:0] mcause;
  logic [`RV_XLEN-1:0] value;
  logic hit;

  always_comb begin
    value = '0;
    hit = 1'b1;
    case (req.addr)
      `CSR_MSTATUS: value = mstatus;
      `CSR_MSCRATCH: value = mscratch;
      `CSR_MTVEC: value = mtvec;
      `CSR_MEPC: value = mepc;
      `CSR_MCAUSE: value = mcause;
      default: hit = 1'b0;
    endcase
  end

  assign rsp.rdata = req.rd ? value : '0;
  assign rsp.hit = hit;

  always_ff @(posedge clock) begin
    if (!reset) begin
      mstatus <= '0;
      mscratch <= '0;
      mtvec <= `RV_RESET_TVEC;
      mepc <= '0;
      mcause <= '0;
    end else if (req.wr) begin
      case (req.addr)
        `CSR_MSTATUS: mstatus <= req.wdata & mstatus_mask;
        `CSR_MSCRATCH: mscratch <= req.wdata;
        `CSR_MTVEC: mtvec <= req.wdata;
        `CSR_MEPC: mepc <= {req.wdata[`RV_XLEN-1:1], 1'b0};  // Always aligned
        `CSR_MCAUSE: mcause <= req.wdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/csr_port_arbiter.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module csr_port_arbiter (
  input  logic clock,
  input  logic reset,
  input  rv_decode_pkg::csr_req_t dec_req,
  output rv_decode_pkg::csr_rsp_t dec_rsp,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [`RV_CADDR_W-1:0] paddr,
  input  logic [`RV_XLEN-1:0] pwdata,
  output logic [`RV_XLEN-1:0] prdata,
  output logic pready,
  output logic pslverr,
  output rv_decode_pkg::csr_req_t csr_req,
  input  rv_decode_pkg::csr_rsp_t csr_rsp
);
  typedef enum logic {
    arb_idle,
    arb_access
  } arb_state_t;

  arb_state_t state;
  logic host_grant;

  // Decode read wins and the host waits in its access phase
  assign host_grant = psel & penable & ~dec_req.rd & (state == arb_idle);

  always_comb begin
    csr_req = '0;
    if (dec_req.rd) begin
      csr_req = dec_req;
    end else if (host_grant) begin
      csr_req.rd = ~pwrite;
      csr_req.wr = pwrite;  // Commits on the completing edge
      csr_req.addr = paddr;
      csr_req.wdata = pwdata;
    end
  end

  assign dec_rsp = csr_rsp;
  assign pready = host_grant;
  assign pslverr = host_grant & ~csr_rsp.hit;
  assign prdata = (host_grant && !pwrite) ? csr_rsp.rdata : '0;

  // Access marks a finished transfer until penable drops
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= arb_idle;
    end else if (host_grant) begin
      state <= arb_access;
    end else if (!(psel && penable)) begin
      state <= arb_idle;
    end
  end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module decode_stage (
  input  logic clock,
  input  logic reset,
  input  rv_decode_pkg::fetch_in_t fetch,
  input  rv_decode_pkg::stage_hazard_t ex_state,
  input  rv_decode_pkg::stage_hazard_t mem_state,
  input  logic flush,
  output logic [31:0] dec_instr,
  input  rv_decode_pkg::decoder_out_t dec_result,
  output rv_decode_pkg::reg_read_req_t reg_read,
  output rv_decode_pkg::csr_req_t csr_req,
  input  rv_decode_pkg::csr_rsp_t csr_rsp,
  output rv_decode_pkg::decode_instr_t decoded,
  output logic stall
);
  import rv_decode_pkg::*;

  decode_instr_t cur;
  decode_instr_t nxt;
  decode_instr_t rec_in;
  logic [`RV_XLEN-1:0] step;
  logic hazard;
  logic bubble;
  logic hold;

  assign dec_instr = fetch.instr;
  assign step = (fetch.instr[1:0] == 2'b11) ? `RV_XLEN'(4) : `RV_XLEN'(2);

  // Read requests leave straight from the fetch word
  assign reg_read.rden1 = fetch.valid & dec_result.op.rden1;
  assign reg_read.rden2 = fetch.valid & dec_result.op.rden2;
  assign reg_read.raddr1 = fetch.instr[19:15];
  assign reg_read.raddr2 = fetch.instr[24:20];

  assign csr_req.rd = fetch.valid & dec_result.op.crden;
  assign csr_req.wr = 1'b0;
  assign csr_req.addr = fetch.instr[31:20];
  assign csr_req.wdata = '0;

  always_comb begin
    nxt = '0;
    nxt.pc = fetch.pc;
    nxt.npc = fetch.pc + step;
    nxt.instr = fetch.instr;
    nxt.waddr = fetch.instr[11:7];
    nxt.raddr1 = fetch.instr[19:15];
    nxt.raddr2 = fetch.instr[24:20];
    nxt.caddr = fetch.instr[31:20];
    nxt.imm = dec_result.imm;
    nxt.cdata = csr_rsp.rdata;
    nxt.op = fetch.valid ? dec_result.op : '0;
    nxt.alu_op = dec_result.alu_op;
    nxt.bcu_op = dec_result.bcu_op;
    nxt.lsu_op = dec_result.lsu_op;
    nxt.csr_op = dec_result.csr_op;
    nxt.muldiv_op = dec_result.muldiv_op;
    if (fetch.valid) begin
      // Unimplemented CSR counts as illegal
      if (!dec_result.op.valid || (dec_result.op.crden && !csr_rsp.hit)) begin
        nxt.op.exception = 1'b1;
        nxt.ecause = except_illegal_instruction;
        nxt.etval = fetch.instr;
      end else if (dec_result.op.ebreak) begin
        nxt.op.exception = 1'b1;
        nxt.ecause = except_breakpoint;
      end else if (dec_result.op.ecall) begin
        nxt.op.exception = 1'b1;
        nxt.ecause = except_env_call_mach;
      end
    end
  end

  // Load-use, CSR write and divider hazards
  assign hazard = ex_state.op.cwren | mem_state.op.cwren | ex_state.op.division |
                  (ex_state.op.load &
                   ((reg_read.rden1 & (ex_state.waddr == reg_read.raddr1)) |
                    (reg_read.rden2 & (ex_state.waddr == reg_read.raddr2))));
  assign stall = hazard & ~flush;
  assign hold = ex_state.stall | mem_state.stall;  // Back-pressure from later stages
  assign bubble = hazard | flush | ex_state.op.jump | ex_state.op.fence |
                  ex_state.op.mret | ex_state.op.exception;

  always_comb begin
    rec_in = nxt;
    if (bubble) rec_in.op = '0;
    if (hold && !flush) rec_in = cur;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      cur <= '0;
    end else begin
      cur <= rec_in;
    end
  end

  assign decoded = cur;

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module instr_decoder (
  input  logic [31:0] instr,
  output rv_decode_pkg::decoder_out_t result
);
  import rv_decode_pkg::*;

  typedef enum logic [6:0] {
    opc_load = 7'b0000011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm = 7'b0010011,
    opc_auipc = 7'b0010111,
    opc_store = 7'b0100011,
    opc_op = 7'b0110011,
    opc_lui = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr = 7'b1100111,
    opc_jal = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, zimm;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign zimm = {27'b0, instr[19:15]};  // CSR immediate forms

  always_comb begin
    result = '0;
    result.imm = imm_i;
    case (opcode)
      opc_lui, opc_auipc: begin
        result.op.wren = 1'b1;
        result.op.lui = (opcode == opc_lui);
        result.op.auipc = (opcode == opc_auipc);
        result.op.valid = 1'b1;
        result.alu_op = (opcode == opc_lui) ? alu_pass_b : alu_add;
        result.imm = imm_u;
      end
      opc_jal, opc_jalr: begin
        result.op.wren = 1'b1;
        result.op.rden1 = (opcode == opc_jalr);
        result.op.jal = (opcode == opc_jal);
        result.op.jalr = (opcode == opc_jalr);
        result.op.jump = 1'b1;
        result.op.valid = (opcode == opc_jal) || (funct3 == 3'b000);
        if (opcode == opc_jal) result.imm = imm_j;
      end
      opc_branch: begin
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.branch = 1'b1;
        result.op.valid = (funct3[2:1] != 2'b01);
        result.imm = imm_b;
        case (funct3)
          3'b000: result.bcu_op = bcu_beq;
          3'b001: result.bcu_op = bcu_bne;
          3'b100: result.bcu_op = bcu_blt;
          3'b101: result.bcu_op = bcu_bge;
          3'b110: result.bcu_op = bcu_bltu;
          default: result.bcu_op = bcu_bgeu;
        endcase
      end
      opc_load: begin
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.load = 1'b1;
        result.op.valid = 1'b1;
        case (funct3)
          3'b000: result.lsu_op = lsu_lb;
          3'b001: result.lsu_op = lsu_lh;
          3'b010: result.lsu_op = lsu_lw;
          3'b100: result.lsu_op = lsu_lbu;
          3'b101: result.lsu_op = lsu_lhu;
          default: result.op.valid = 1'b0;
        endcase
      end
      opc_store: begin
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.store = 1'b1;
        result.op.valid = 1'b1;
        result.imm = imm_s;
        case (funct3)
          3'b000: result.lsu_op = lsu_sb;
          3'b001: result.lsu_op = lsu_sh;
          3'b010: result.lsu_op = lsu_sw;
          default: result.op.valid = 1'b0;
        endcase
      end
      opc_op_imm, opc_op: begin
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.rden2 = (opcode == opc_op);
        result.op.valid = 1'b1;
        if (opcode == opc_op && funct7 == 7'b0000001) begin
          result.op.mult = ~funct3[2];
          result.op.division = funct3[2];
          result.muldiv_op = muldiv_op_t'({1'b0, funct3} + 4'd1);
        end else begin
          case (funct3)
            3'b000: result.alu_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
            3'b001: result.alu_op = alu_sll;
            3'b010: result.alu_op = alu_slt;
            3'b011: result.alu_op = alu_sltu;
            3'b100: result.alu_op = alu_xor;
            3'b101: result.alu_op = funct7[5] ? alu_sra : alu_srl;
            3'b110: result.alu_op = alu_or;
            default: result.alu_op = alu_and;
          endcase
          // Only sub and sra may carry funct7 = 0100000
          if (opcode == opc_op || funct3[1:0] == 2'b01) begin
            result.op.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 &&
                              (funct3 == 3'b101 || (funct3 == 3'b000 && opcode == opc_op)));
          end
        end
      end
      opc_misc_mem: begin
        result.op.fence = 1'b1;
        result.op.valid = (funct3[2:1] == 2'b00);  // fence and fence.i
      end
      opc_system: begin
        if (funct3 == 3'b000) begin
          result.op.ecall = (instr == 32'h0000_0073);
          result.op.ebreak = (instr == 32'h0010_0073);
          result.op.mret = (instr == 32'h3020_0073);
          result.op.wfi = (instr == 32'h1050_0073);
          result.op.jump = result.op.mret;
          result.op.valid = result.op.ecall | result.op.ebreak | result.op.mret | result.op.wfi;
        end else begin
          result.op.wren = 1'b1;
          result.op.rden1 = ~funct3[2];
          result.op.crden = 1'b1;  // Every CSR access probes the address
          result.op.cwren = ~(funct3[1] && instr[19:15] == 5'd0);
          result.op.valid = (funct3 != 3'b100);
          result.imm = zimm;
          result.csr_op = csr_op_t'({1'b0, funct3[1:0]} + {1'b0, funct3[2], funct3[2]});
        end
      end
      default: result.op.valid = 1'b0;
    endcase
    if (!result.op.valid) result = '0;
  end

endmodule

`default_nettype wire

// File: verilog/rv_decode_pkg.sv
`default_nettype none
`include "rv_decode_defines.svh"

package rv_decode_pkg;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    bcu_none, bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
  } bcu_op_t;

  typedef enum logic [3:0] {
    lsu_none, lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw
  } lsu_op_t;

  typedef enum logic [2:0] {
    csr_none, csr_rw, csr_rs, csr_rc, csr_rwi, csr_rsi, csr_rci
  } csr_op_t;

  // Encoded as funct3 plus one
  typedef enum logic [3:0] {
    md_none, md_mul, md_mulh, md_mulhsu, md_mulhu, md_div, md_divu, md_rem, md_remu
  } muldiv_op_t;

  typedef enum logic [3:0] {
    except_illegal_instruction = 4'd2,
    except_breakpoint = 4'd3,
    except_env_call_mach = 4'd11
  } except_cause_t;

  typedef struct packed {
    logic wren, rden1, rden2, crden, cwren;
    logic auipc, lui, jal, jalr, branch, load, store;
    logic fence, ecall, ebreak, mret, wfi;
    logic mult, division, jump, exception, valid;
  } op_flags_t;

  typedef struct packed {
    op_flags_t op;
    logic [`RV_XLEN-1:0] imm;
    alu_op_t alu_op;
    bcu_op_t bcu_op;
    lsu_op_t lsu_op;
    csr_op_t csr_op;
    muldiv_op_t muldiv_op;
  } decoder_out_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc, npc;
    logic [31:0] instr;
    logic [`RV_RADDR_W-1:0] waddr, raddr1, raddr2;
    logic [`RV_CADDR_W-1:0] caddr;
    logic [`RV_XLEN-1:0] imm, cdata;
    op_flags_t op;
    alu_op_t alu_op;
    bcu_op_t bcu_op;
    lsu_op_t lsu_op;
    csr_op_t csr_op;
    muldiv_op_t muldiv_op;
    except_cause_t ecause;
    logic [`RV_XLEN-1:0] etval;
  } decode_instr_t;

  typedef struct packed {
    logic [`RV_RADDR_W-1:0] waddr;
    op_flags_t op;
    logic stall;
  } stage_hazard_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [31:0] instr;
    logic valid;
  } fetch_in_t;

  typedef struct packed {
    logic rden1, rden2;
    logic [`RV_RADDR_W-1:0] raddr1, raddr2;
  } reg_read_req_t;

  typedef struct packed {
    logic rd, wr;
    logic [`RV_CADDR_W-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] rdata;
    logic hit;
  } csr_rsp_t;

endpackage

`default_nettype wire

// File: verilog/rv_decode_top.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module rv_decode_top (
  input  logic clock,
  input  logic reset,
  input  rv_decode_pkg::fetch_in_t fetch,
  input  rv_decode_pkg::stage_hazard_t ex_state,
  input  rv_decode_pkg::stage_hazard_t mem_state,
  input  logic flush,
  output rv_decode_pkg::reg_read_req_t reg_read,
  output rv_decode_pkg::decode_instr_t decoded,
  output logic stall,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [`RV_CADDR_W-1:0] paddr,
  input  logic [`RV_XLEN-1:0] pwdata,
  output logic [`RV_XLEN-1:0] prdata,
  output logic pready,
  output logic pslverr
);
  import rv_decode_pkg::*;

  logic [31:0] dec_instr;
  decoder_out_t dec_result;
  csr_req_t dec_csr_req;
  csr_rsp_t dec_csr_rsp;
  csr_req_t csr_req;
  csr_rsp_t csr_rsp;

  instr_decoder instr_decoder_inst (.instr(dec_instr), .result(dec_result));

  decode_stage decode_stage_inst (
    .clock, .reset, .fetch, .ex_state, .mem_state, .flush,
    .dec_instr, .dec_result, .reg_read,
    .csr_req (dec_csr_req), .csr_rsp (dec_csr_rsp),
    .decoded, .stall
  );

  csr_port_arbiter csr_port_arbiter_inst (
    .clock, .reset,
    .dec_req (dec_csr_req), .dec_rsp (dec_csr_rsp),
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .csr_req, .csr_rsp
  );

  csr_file csr_file_inst (.clock, .reset, .req(csr_req), .rsp(csr_rsp));

endmodule

`default_nettype wire
